//--- sources.f
+incdir+verif
hdl/rv_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core.sv
verif/rv_core_assert.sv
verif/tb_rv_core.sv

//--- verif/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// results land in consecutive words from here on
localparam logic [31:0] STORE_BASE = 32'h0000_0400;
localparam logic [11:0] BAD_ADDR   = 12'h7f0;

logic [31:0] lfsr_state = 32'd34;

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input rv_opcode_e opc);
    return {f7, rs2, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input rv_opcode_e opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, FUNCT3_WORD, imm[4:0], OPC_STORE, 2'b11};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH, 2'b11};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input rv_opcode_e opc);
    return {imm, rd, opc, 2'b11};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, 2'b11};
endfunction

task automatic emit(input logic [31:0] inst);
    imem[prog_len] = inst;
    prog_len++;
endtask

// sw of rs to the next result word, with the value expected there
task automatic store_reg(input logic [4:0] rs, input logic [31:0] value, input string name);
    logic [31:0] addr;
    addr = STORE_BASE + 32'(exp_addr.size() * 4);
    emit(enc_s(addr[11:0], rs, 5'd0));
    exp_addr.push_back(addr);
    exp_data.push_back(value);
    exp_name.push_back(name);
endtask

// lui takes the rounded upper part so that the signed addi lands exactly
task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(enc_u(upper[31:12], rd, OPC_LUI));
    emit(enc_i(value[11:0], rd, FUNCT3_ADD_SUB, rd, OPC_OP_IMM));
endtask

task automatic build_program();
    string       names [10] = '{"add", "sub", "sll", "slt", "sltu",
                                "xor", "srl", "sra", "or", "and"};
    logic [3:0]  codes [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    string       br_names [6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
    logic [2:0]  br_f3 [6] = '{FUNCT3_BEQ, FUNCT3_BNE, FUNCT3_BLT,
                               FUNCT3_BGE, FUNCT3_BLTU, FUNCT3_BGEU};
    logic [11:0] imm12;
    logic [19:0] upper;
    int          pc_here;
    prog_len = 0;
    op_a = take_bits(32);
    op_b = take_bits(32);
    // nop at the reset pc
    emit(enc_i(12'h000, 5'd0, FUNCT3_ADD_SUB, 5'd0, OPC_OP_IMM));
    load_const(5'd1, op_a);
    load_const(5'd2, op_b);
    for (int k = 0; k < 10; k++) begin
        emit(enc_r({1'b0, codes[k][3], 5'b0}, 5'd2, 5'd1, codes[k][2:0], 5'd3, OPC_OP));
        store_reg(5'd3, alu_ref(codes[k], op_a, op_b), names[k]);
    end
    // immediate forms, there is no subi
    for (int k = 0; k < 10; k++) begin
        if (k == 1) continue;
        imm12 = 12'(take_bits(12));
        if (codes[k][1:0] == 2'b01) imm12 = {1'b0, codes[k][3], 5'b0, imm12[4:0]};
        emit(enc_i(imm12, 5'd1, codes[k][2:0], 5'd3, OPC_OP_IMM));
        store_reg(5'd3, alu_ref(codes[k], op_a, {{20{imm12[11]}}, imm12}),
                  {names[k], " imm"});
    end
    upper = 20'(take_bits(20));
    emit(enc_u(upper, 5'd3, OPC_LUI));
    store_reg(5'd3, {upper, 12'h000}, "lui");
    pc_here = prog_len * 4;
    emit(enc_u(upper, 5'd3, OPC_AUIPC));
    store_reg(5'd3, 32'(pc_here) + {upper, 12'h000}, "auipc");
    // marker 1 means the addi behind the branch ran
    for (int k = 0; k < 6; k++) begin
        emit(enc_i(12'h000, 5'd0, FUNCT3_ADD_SUB, 5'd4, OPC_OP_IMM));
        emit(enc_b(13'd8, 5'd2, 5'd1, br_f3[k]));
        emit(enc_i(12'h001, 5'd0, FUNCT3_ADD_SUB, 5'd4, OPC_OP_IMM));
        store_reg(5'd4, branch_ref(br_f3[k], op_a, op_b) ? 32'd0 : 32'd1, br_names[k]);
    end
    // the skipped word is a stray store, so a missed jump shows a wrong address
    pc_here = prog_len * 4;
    emit(enc_j(21'd8, 5'd5));
    emit(enc_s(BAD_ADDR, 5'd0, 5'd0));
    store_reg(5'd5, 32'(pc_here + 4), "jal");
    pc_here = prog_len * 4;
    emit(enc_i(12'(pc_here + 9), 5'd0, 3'b000, 5'd6, OPC_JALR));
    emit(enc_s(BAD_ADDR, 5'd0, 5'd0));
    store_reg(5'd6, 32'(pc_here + 4), "jalr");
    emit(enc_i(STORE_BASE[11:0], 5'd0, FUNCT3_WORD, 5'd7, OPC_LOAD));
    store_reg(5'd7, exp_data[0], "lw");
    emit(enc_i(12'h001, 5'd1, FUNCT3_ADD_SUB, 5'd0, OPC_OP_IMM));
    store_reg(5'd0, 32'd0, "x0 write");
    emit(enc_j(21'd0, 5'd0));
endtask

`endif

//--- verif/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core import rv_isa_pkg::*; ();
    localparam int              STORE_TIMEOUT = 200;
    localparam logic [XLEN-1:0] RESET_ADDR    = '0;

    logic            i_clk = 1'b0;
    logic            i_rst_n;
    logic [XLEN-1:0] o_imem_addr;
    logic [XLEN-1:0] i_imem_rdata;
    logic [XLEN-1:0] o_dmem_addr;
    logic [XLEN-1:0] o_dmem_wdata;
    logic [XLEN-1:0] i_dmem_rdata;
    logic            o_dmem_wen;
    logic            o_dmem_ren;

    logic [XLEN-1:0] imem [256];
    logic [XLEN-1:0] dmem [1024];
    int              prog_len;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    string           exp_name [$];

    always #5 i_clk = ~i_clk;

    rv_core UUT (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_imem_addr  (o_imem_addr),
        .i_imem_rdata (i_imem_rdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_ren   (o_dmem_ren)
    );

    // both memories read combinationally
    assign i_imem_rdata = imem[o_imem_addr[9:2]];
    // data reads return the inverted word unless the core asks for a read
    assign i_dmem_rdata = o_dmem_ren ? dmem[o_dmem_addr[11:2]]
                                     : ~dmem[o_dmem_addr[11:2]];

    always @(posedge i_clk) begin
        if (o_dmem_wen) begin
            dmem[o_dmem_addr[11:2]] <= o_dmem_wdata;
        end
    end

    // reference alu where code is {funct7 bit 5, funct3}
    function automatic logic [XLEN-1:0] alu_ref(input logic [3:0] code,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (code[2:0])
            FUNCT3_ADD_SUB: return code[3] ? a - b : a + b;
            FUNCT3_SLL:     return a << b[4:0];
            FUNCT3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FUNCT3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            FUNCT3_XOR:     return a ^ b;
            FUNCT3_SRL_SRA: return code[3] ? XLEN'($signed(a) >>> b[4:0]) : a >> b[4:0];
            FUNCT3_OR:      return a | b;
            default:        return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
        case (f3)
            FUNCT3_BEQ:  return a == b;
            FUNCT3_BNE:  return a != b;
            FUNCT3_BLT:  return $signed(a) < $signed(b);
            FUNCT3_BGE:  return $signed(a) >= $signed(b);
            FUNCT3_BLTU: return a < b;
            default:     return a >= b;
        endcase
    endfunction

    `include "tb_program.svh"

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic fill_memories();
        for (int i = 0; i < 256; i++) begin
            // nop carrying its own word address in the immediate
            imem[i] = enc_i(12'(i * 4), 5'd0, FUNCT3_ADD_SUB, 5'd0, OPC_OP_IMM);
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = 32'hd00d_0000 ^ 32'(i * 4);
        end
    endtask

    // next store must hit the expected word with the expected data
    task automatic wait_store(input int idx);
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (!o_dmem_wen) begin
            if (cycles >= STORE_TIMEOUT) begin
                abort_run($sformatf("timeout: store %0d (%s) never arrived",
                                    idx, exp_name[idx]));
            end else begin
                cycles++;
                @(negedge i_clk);
            end
        end
        assert (o_dmem_addr == exp_addr[idx] && o_dmem_wdata == exp_data[idx]) else
            abort_run($sformatf("** Error at %0t: %s stored %h at %h, expected %h at %h",
                                $time, exp_name[idx], o_dmem_wdata, o_dmem_addr,
                                exp_data[idx], exp_addr[idx]));
    endtask

    always @(negedge i_clk) begin
        if (UUT.u_assert.error_count != 0) begin
            abort_run("a protocol assertion bound into the core failed");
        end
    end

    initial begin
        i_rst_n <= 1'b0;
        fill_memories();
        build_program();
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        assert (o_imem_addr == RESET_ADDR) else
            abort_run($sformatf("** Error at %0t: first fetch at %h", $time, o_imem_addr));
        @(negedge i_clk);
        assert (o_imem_addr == RESET_ADDR + 32'd4) else
            abort_run($sformatf("** Error at %0t: second fetch at %h", $time, o_imem_addr));
        for (int idx = 0; idx < exp_data.size(); idx++) begin
            wait_store(idx);
        end
        if (UUT.u_assert.error_count != 0) begin
            abort_run("a protocol assertion bound into the core failed");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- verif/rv_core_assert.sv
`timescale 1ns/1ns

module rv_core_assert import rv_isa_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input logic            i_clk,
    input logic            i_rst_n,
    input logic [XLEN-1:0] i_imem_addr,
    input logic [XLEN-1:0] i_dmem_addr,
    input logic            i_dmem_wen,
    input logic            i_dmem_ren
);
    // number of failed assertions
    int error_count = 0;

    // an access is a load or a store, never both
    property p_one_access;
        @(posedge i_clk) !(i_dmem_wen && i_dmem_ren);
    endproperty

    property p_reset_quiet;
        @(posedge i_clk) !i_rst_n |-> (i_imem_addr == RESET_PC && !i_dmem_wen && !i_dmem_ren);
    endproperty

    property p_word_aligned;
        @(posedge i_clk) (i_imem_addr[1:0] == 2'b00) && (i_dmem_addr[1:0] == 2'b00);
    endproperty

    a_one_access: assert property (p_one_access) else begin
        error_count++;
        $error("data memory read and write enables are both high");
    end

    a_reset_quiet: assert property (p_reset_quiet) else begin
        error_count++;
        $error("pc left the reset address or an enable was high during reset");
    end

    a_word_aligned: assert property (p_word_aligned) else begin
        error_count++;
        $error("instruction or data address is not word aligned");
    end

endmodule

bind rv_core rv_core_assert #(.RESET_PC(RESET_PC)) u_assert (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_imem_addr (o_imem_addr),
    .i_dmem_addr (o_dmem_addr),
    .i_dmem_wen  (o_dmem_wen),
    .i_dmem_ren  (o_dmem_ren)
);

//--- hdl/rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_isa_pkg::*; import core_ctrl_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    output logic [XLEN-1:0] o_imem_addr,
    input  logic [XLEN-1:0] i_imem_rdata,
    output logic [XLEN-1:0] o_dmem_addr,
    output logic [XLEN-1:0] o_dmem_wdata,
    input  logic [XLEN-1:0] i_dmem_rdata,
    output logic            o_dmem_wen,
    output logic            o_dmem_ren
);
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       imm;
    ctrl_t                 ctrl;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       alu_result;
    logic                  take;
    logic [XLEN-1:0]       pc;

    // fetch is just the pc on the instruction port
    assign o_imem_addr = pc;

    rv_decode u_decode (
        .i_inst     (i_imem_rdata),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr),
        .o_rd_addr  (rd_addr),
        .o_imm      (imm),
        .o_ctrl     (ctrl)
    );

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_rd_addr  (rd_addr),
        .i_rd_wen   (ctrl.rd_wen),
        .i_rd_wdata (rd_wdata),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_execute u_execute (
        .i_ctrl       (ctrl),
        .i_pc         (pc),
        .i_imm        (imm),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_alu_result (alu_result),
        .o_take       (take)
    );

    rv_result #(
        .RESET_PC (RESET_PC)
    ) u_result (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_ctrl       (ctrl),
        .i_alu_result (alu_result),
        .i_rs2_data   (rs2_data),
        .i_dmem_rdata (i_dmem_rdata),
        .i_take       (take),
        .o_pc         (pc),
        .o_rd_wdata   (rd_wdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_ren   (o_dmem_ren)
    );

endmodule

//--- hdl/rv_result.sv
`timescale 1ns/1ns

module rv_result import rv_isa_pkg::*; import core_ctrl_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  ctrl_t           i_ctrl,
    input  logic [XLEN-1:0] i_alu_result,
    input  logic [XLEN-1:0] i_rs2_data,
    input  logic [XLEN-1:0] i_dmem_rdata,
    input  logic            i_take,
    output logic [XLEN-1:0] o_pc,
    output logic [XLEN-1:0] o_rd_wdata,
    output logic [XLEN-1:0] o_dmem_addr,
    output logic [XLEN-1:0] o_dmem_wdata,
    output logic            o_dmem_wen,
    output logic            o_dmem_ren
);
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;

    assign pc_plus4 = o_pc + XLEN'(4);
    // jalr targets may be odd, bit 0 is dropped
    assign next_pc  = i_take ? {i_alu_result[XLEN-1:1], 1'b0} : pc_plus4;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= RESET_PC;
        end else begin
            o_pc <= next_pc;
        end
    end

    always_comb begin
        case (i_ctrl.wb_sel)
            WB_MEM:      o_rd_wdata = i_dmem_rdata;
            WB_PC_PLUS4: o_rd_wdata = pc_plus4;
            default:     o_rd_wdata = i_alu_result;
        endcase
    end

    // word accesses only
    assign o_dmem_addr  = {i_alu_result[XLEN-1:2], 2'b00};
    assign o_dmem_wdata = i_rs2_data;
    assign o_dmem_wen   = i_ctrl.mem_wen;
    assign o_dmem_ren   = i_ctrl.mem_ren;

endmodule

//--- hdl/rv_execute.sv
`timescale 1ns/1ns

module rv_execute import rv_isa_pkg::*; import core_ctrl_pkg::*; (
    input  ctrl_t           i_ctrl,
    input  logic [XLEN-1:0] i_pc,
    input  logic [XLEN-1:0] i_imm,
    input  logic [XLEN-1:0] i_rs1_data,
    input  logic [XLEN-1:0] i_rs2_data,
    output logic [XLEN-1:0] o_alu_result,
    output logic            o_take
);
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] cmp_op2;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic            cond;
    logic [4:0]      shamt;
    logic            shift_left;
    logic            fill;
    logic [XLEN-1:0] shift_in;
    logic [XLEN-1:0] shift_out;
    logic [XLEN-1:0] shift_result;

    assign op1     = i_ctrl.op1_pc ? i_pc : i_rs1_data;
    assign op2     = i_ctrl.op2_imm ? i_imm : i_rs2_data;
    assign cmp_op2 = i_ctrl.cmp_op2_imm ? i_imm : i_rs2_data;

    // comparator, shared by slt/sltu and the branches
    assign eq  = (i_rs1_data == cmp_op2);
    assign ltu = (i_rs1_data < cmp_op2);
    assign lt  = (i_rs1_data[XLEN-1] != cmp_op2[XLEN-1]) ? i_rs1_data[XLEN-1] : ltu;

    assign cond   = (i_ctrl.br_funct[2] ? (i_ctrl.br_funct[1] ? ltu : lt) : eq)
                    ^ i_ctrl.br_funct[0];
    assign o_take = i_ctrl.jump || (i_ctrl.branch && cond);

    assign shamt      = op2[4:0];
    assign shift_left = (i_ctrl.alu_op == ALU_SLL);
    assign fill       = (i_ctrl.alu_op == ALU_SRA) && op1[XLEN-1];

    // left shifts go through the right shifter on the bit-reversed word
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            shift_in[i] = shift_left ? op1[XLEN-1-i] : op1[i];
        end
    end

    // five log stages, 1/2/4/8/16
    always_comb begin
        logic [XLEN-1:0]   stage;
        logic [2*XLEN-1:0] wide;
        stage = shift_in;
        for (int s = 0; s < 5; s++) begin
            wide = {{XLEN{fill}}, stage} >> (1 << s);
            if (shamt[s]) begin
                stage = wide[XLEN-1:0];
            end
        end
        shift_out = stage;
    end

    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            shift_result[i] = shift_left ? shift_out[XLEN-1-i] : shift_out[i];
        end
    end

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD:  o_alu_result = op1 + op2;
            ALU_SUB:  o_alu_result = op1 - op2;
            ALU_AND:  o_alu_result = op1 & op2;
            ALU_OR:   o_alu_result = op1 | op2;
            ALU_XOR:  o_alu_result = op1 ^ op2;
            ALU_SLT:  o_alu_result = {{(XLEN-1){1'b0}}, lt};
            ALU_SLTU: o_alu_result = {{(XLEN-1){1'b0}}, ltu};
            ALU_SLL, ALU_SRL, ALU_SRA: o_alu_result = shift_result;
            default:  o_alu_result = '0;
        endcase
    end

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_isa_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [REG_ADDR_W-1:0] i_rs2_addr,
    input  logic [REG_ADDR_W-1:0] i_rd_addr,
    input  logic                  i_rd_wen,
    input  logic [XLEN-1:0]       i_rd_wdata,
    output logic [XLEN-1:0]       o_rs1_data,
    output logic [XLEN-1:0]       o_rs2_data
);
    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_wdata;
        end
    end

    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/1ns

module rv_decode import rv_isa_pkg::*; import core_ctrl_pkg::*; (
    input  logic [XLEN-1:0]       i_inst,
    output logic [REG_ADDR_W-1:0] o_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_rs2_addr,
    output logic [REG_ADDR_W-1:0] o_rd_addr,
    output logic [XLEN-1:0]       o_imm,
    output ctrl_t                 o_ctrl
);
    rv_opcode_e    opcode;
    logic [2:0]    funct3;
    logic          alt;
    alu_op_e       alu_fn;

    assign opcode = rv_opcode_e'(i_inst[OPCODE_LSB +: OPCODE_W]);
    assign funct3 = i_inst[FUNCT3_LSB +: FUNCT3_W];
    assign alt    = i_inst[ALT_BIT];

    // lui adds its immediate to x0
    assign o_rs1_addr = (opcode == OPC_LUI) ? '0 : i_inst[RS1_LSB +: REG_ADDR_W];
    assign o_rs2_addr = i_inst[RS2_LSB +: REG_ADDR_W];
    assign o_rd_addr  = i_inst[RD_LSB +: REG_ADDR_W];

    // alu function for op and op_imm
    always_comb begin
        case (funct3)
            FUNCT3_ADD_SUB: alu_fn = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            FUNCT3_SLL:     alu_fn = ALU_SLL;
            FUNCT3_SLT:     alu_fn = ALU_SLT;
            FUNCT3_SLTU:    alu_fn = ALU_SLTU;
            FUNCT3_XOR:     alu_fn = ALU_XOR;
            FUNCT3_SRL_SRA: alu_fn = alt ? ALU_SRA : ALU_SRL;
            FUNCT3_OR:      alu_fn = ALU_OR;
            default:        alu_fn = ALU_AND;
        endcase
    end

    always_comb begin
        o_ctrl          = '0;
        o_ctrl.alu_op   = ALU_ADD;
        o_ctrl.wb_sel   = WB_ALU;
        o_ctrl.br_funct = funct3;
        case (opcode)
            OPC_OP: begin
                o_ctrl.alu_op = alu_fn;
                o_ctrl.rd_wen = 1'b1;
            end
            OPC_OP_IMM: begin
                o_ctrl.alu_op      = alu_fn;
                o_ctrl.op2_imm     = 1'b1;
                o_ctrl.cmp_op2_imm = 1'b1;
                o_ctrl.rd_wen      = 1'b1;
            end
            OPC_LUI: begin
                o_ctrl.op2_imm = 1'b1;
                o_ctrl.rd_wen  = 1'b1;
            end
            OPC_AUIPC: begin
                o_ctrl.op1_pc  = 1'b1;
                o_ctrl.op2_imm = 1'b1;
                o_ctrl.rd_wen  = 1'b1;
            end
            OPC_LOAD: begin
                o_ctrl.op2_imm = 1'b1;
                o_ctrl.rd_wen  = 1'b1;
                o_ctrl.wb_sel  = WB_MEM;
                o_ctrl.mem_ren = 1'b1;
            end
            OPC_STORE: begin
                o_ctrl.op2_imm = 1'b1;
                o_ctrl.mem_wen = 1'b1;
            end
            // branch target is pc + imm while the comparator decides
            OPC_BRANCH: begin
                o_ctrl.op1_pc  = 1'b1;
                o_ctrl.op2_imm = 1'b1;
                o_ctrl.branch  = 1'b1;
            end
            OPC_JAL: begin
                o_ctrl.op1_pc  = 1'b1;
                o_ctrl.op2_imm = 1'b1;
                o_ctrl.rd_wen  = 1'b1;
                o_ctrl.wb_sel  = WB_PC_PLUS4;
                o_ctrl.jump    = 1'b1;
            end
            OPC_JALR: begin
                o_ctrl.op2_imm = 1'b1;
                o_ctrl.rd_wen  = 1'b1;
                o_ctrl.wb_sel  = WB_PC_PLUS4;
                o_ctrl.jump    = 1'b1;
            end
            // fence, system and unknown opcodes retire as nops
            default: ;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:
                o_imm = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
            OPC_STORE:
                o_imm = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            OPC_BRANCH:
                o_imm = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25],
                         i_inst[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                o_imm = {i_inst[31:12], 12'b0};
            OPC_JAL:
                o_imm = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20],
                         i_inst[30:21], 1'b0};
            default:
                o_imm = '0;
        endcase
    end

endmodule

//--- hdl/core_ctrl_pkg.sv
package core_ctrl_pkg;

    // operations the execute stage can perform
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // source of the register write-back value
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS4
    } wb_sel_e;

    // everything decode hands to execute and result
    typedef struct packed {
        alu_op_e    alu_op;
        logic       op1_pc;
        logic       op2_imm;
        logic       cmp_op2_imm;
        logic       rd_wen;
        wb_sel_e    wb_sel;
        logic       jump;
        logic       branch;
        logic [2:0] br_funct;
        logic       mem_ren;
        logic       mem_wen;
    } ctrl_t;

endpackage

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // data path and register file geometry
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes live in inst[6:2], the low two bits are always 2'b11
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011,
        OPC_SYSTEM   = 5'b11100
    } rv_opcode_e;

    // funct3 codes shared by op and op_imm
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // branch conditions
    // bit 2 clear selects equality, bit 1 unsigned, bit 0 inverts
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    // word access width for lw and sw
    localparam logic [2:0] FUNCT3_WORD = 3'b010;

    // instruction field positions
    localparam int OPCODE_LSB = 2;
    localparam int OPCODE_W   = 5;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_W   = 3;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    // funct7 bit 5 picks sub and sra
    localparam int ALT_BIT = FUNCT7_LSB + 5;

endpackage
